/* Makefile */
TOP = tb_keyboard_parser

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* files.f */
kbd_pkg.sv
ps2_receiver.sv
prefix_fsm.sv
key_state_table.sv
keyboard_parser.sv
kbd_checker.sv
tb_keyboard_parser.sv

/* kbd_checker.sv */
`timescale 1ns/1ps

module kbd_checker #(
	parameter int NUM_KEYS = 128
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	input  logic [NUM_KEYS-1:0] key_data,
	input  logic [NUM_KEYS-1:0] ext_key_data,
	output int                  error_count,
	output int                  check_count
);

	localparam logic [NUM_KEYS-1:0] ONE_HOT = 1;

	logic [NUM_KEYS-1:0] model_keys;
	logic [NUM_KEYS-1:0] model_ext;
	logic                ext_pending;
	logic                break_pending;
	logic [10:0]         frame_bits;
	int                  bit_idx;
	logic                clk_prev;
	logic                armed;
	int                  idle_cycles;
	logic                compare_now;

	// Prefix rules applied to one good byte.
	task automatic apply_byte(input logic [7:0] b);
		logic [NUM_KEYS-1:0] mask;
		mask = (int'(b) < NUM_KEYS) ? (ONE_HOT << b) : '0;
		if (!break_pending && b == 8'hF0) begin
			break_pending = 1'b1;
		end else if (!break_pending && !ext_pending && b == 8'hE0) begin
			ext_pending = 1'b1;
		end else begin
			if (ext_pending) begin
				model_ext = break_pending ? (model_ext & ~mask) : (model_ext | mask);
			end else begin
				model_keys = break_pending ? (model_keys & ~mask) : (model_keys | mask);
			end
			ext_pending   = 1'b0;
			break_pending = 1'b0;
		end
	endtask

	// Pins are sampled on the rising clk edge, away from the stimulus edge.
	always @(posedge clk) begin
		compare_now = 1'b0;
		if (reset) begin
			model_keys    = '0;
			model_ext     = '0;
			ext_pending   = 1'b0;
			break_pending = 1'b0;
			frame_bits    = '0;
			bit_idx       = 0;
			clk_prev      = 1'b1;
			armed         = 1'b1;
			idle_cycles   = 0;
		end else begin
			if (clk_prev && !ps2_clk) begin
				frame_bits = {ps2_data, frame_bits[10:1]};
				bit_idx++;
				if (bit_idx == 11) begin
					bit_idx     = 0;
					armed       = 1'b1;
					idle_cycles = 0;
					// Start low, odd parity over data and parity, stop high.
					if (!frame_bits[0] && (^frame_bits[9:1]) && frame_bits[10]) begin
						apply_byte(frame_bits[8:1]);
					end
				end
			end else if (armed && bit_idx == 0) begin
				idle_cycles++;
				if (idle_cycles == 16) begin
					compare_now = 1'b1;
					armed       = 1'b0;
				end
			end
			clk_prev = ps2_clk;
		end
	end

	// Bitmaps settle on the rising edge, so compare on the falling one.
	always @(negedge clk) begin
		if (reset) begin
			error_count = 0;
			check_count = 0;
		end else if (compare_now) begin
			check_count++;
			if (key_data !== model_keys) begin
				error_count++;
				$display("FAIL t=%0t: key_data is %h, model has %h",
					$time, key_data, model_keys);
			end
			if (ext_key_data !== model_ext) begin
				error_count++;
				$display("FAIL t=%0t: ext_key_data is %h, model has %h",
					$time, ext_key_data, model_ext);
			end
		end
	end

endmodule

/* kbd_pkg.sv */
package kbd_pkg;

	// PS/2 data byte.
	parameter int SCAN_W = 8;

	typedef logic [SCAN_W-1:0] scan_code_t;

	// Prefixes sent ahead of extended and release codes.
	parameter scan_code_t PREFIX_EXT   = 8'hE0;
	parameter scan_code_t PREFIX_BREAK = 8'hF0;

	// Prefix parser states.
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXT_SEEN,
		ST_BREAK_SEEN,
		ST_CODE_SEEN
	} parser_state_t;

	// Command applied to the key table.
	typedef enum logic {
		ACT_PRESS,
		ACT_RELEASE
	} key_action_t;

endpackage

/* key_state_table.sv */
`timescale 1ns/1ps

module key_state_table #(
	parameter int NUM_KEYS = 128
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  kbd_pkg::scan_code_t  cmd_code,
	input  kbd_pkg::key_action_t cmd_action,
	input  logic                 cmd_ext,
	output logic [NUM_KEYS-1:0]  key_data,
	output logic [NUM_KEYS-1:0]  ext_key_data
);
	import kbd_pkg::*;

	logic                in_range;
	logic [NUM_KEYS-1:0] key_mask;

	// One-hot select of the addressed key.
	assign in_range = int'(cmd_code) < NUM_KEYS;
	assign key_mask = in_range ? (NUM_KEYS'(1) << cmd_code) : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			key_data     <= '0;
			ext_key_data <= '0;
		end else if (cmd_valid) begin
			if (cmd_ext) begin
				if (cmd_action == ACT_PRESS) begin
					ext_key_data <= ext_key_data | key_mask;
				end else begin
					ext_key_data <= ext_key_data & ~key_mask;
				end
			end else if (cmd_action == ACT_PRESS) begin
				key_data <= key_data | key_mask;
			end else begin
				key_data <= key_data & ~key_mask;
			end
		end
	end

	// At most one key moves per clock.
	a_one_bit_change: assert property (
		@(posedge clk) disable iff (reset)
		!$past(reset) |-> $countones({key_data ^ $past(key_data),
			ext_key_data ^ $past(ext_key_data)}) <= 1
	);

endmodule

/* keyboard_parser.sv */
`timescale 1ns/1ps

module keyboard_parser #(
	parameter int NUM_KEYS = 128
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	output logic [NUM_KEYS-1:0] key_data,
	output logic [NUM_KEYS-1:0] ext_key_data
);
	import kbd_pkg::*;

	scan_code_t  rx_byte;
	logic        rx_valid;
	logic        cmd_valid;
	scan_code_t  cmd_code;
	key_action_t cmd_action;
	logic        cmd_ext;

	ps2_receiver u_receiver (
		.clk      (clk),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.rx_byte  (rx_byte),
		.rx_valid (rx_valid)
	);

	prefix_fsm u_prefix_fsm (
		.clk        (clk),
		.reset      (reset),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.cmd_valid  (cmd_valid),
		.cmd_code   (cmd_code),
		.cmd_action (cmd_action),
		.cmd_ext    (cmd_ext)
	);

	key_state_table #(
		.NUM_KEYS (NUM_KEYS)
	) u_key_table (
		.clk          (clk),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd_code     (cmd_code),
		.cmd_action   (cmd_action),
		.cmd_ext      (cmd_ext),
		.key_data     (key_data),
		.ext_key_data (ext_key_data)
	);

endmodule

/* prefix_fsm.sv */
`timescale 1ns/1ps

module prefix_fsm (
	input  logic                 clk,
	input  logic                 reset,
	input  kbd_pkg::scan_code_t  rx_byte,
	input  logic                 rx_valid,
	output logic                 cmd_valid,
	output kbd_pkg::scan_code_t  cmd_code,
	output kbd_pkg::key_action_t cmd_action,
	output logic                 cmd_ext
);
	import kbd_pkg::*;

	parser_state_t state;
	parser_state_t next_state;
	logic          ext_flag;
	logic          break_flag;
	logic          code_take;

	always_comb begin
		next_state = state;
		code_take  = 1'b0;
		case (state)
			ST_IDLE: begin
				if (rx_valid) begin
					if (rx_byte == PREFIX_EXT) begin
						next_state = ST_EXT_SEEN;
					end else if (rx_byte == PREFIX_BREAK) begin
						next_state = ST_BREAK_SEEN;
					end else begin
						next_state = ST_CODE_SEEN;
						code_take  = 1'b1;
					end
				end
			end
			ST_EXT_SEEN: begin
				if (rx_valid) begin
					if (rx_byte == PREFIX_BREAK) begin
						next_state = ST_BREAK_SEEN;
					end else begin
						next_state = ST_CODE_SEEN;
						code_take  = 1'b1;
					end
				end
			end
			// Whatever follows F0 is the code.
			ST_BREAK_SEEN: begin
				if (rx_valid) begin
					next_state = ST_CODE_SEEN;
					code_take  = 1'b1;
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Prefix flags, taken with the byte that sets them.
	always_ff @(posedge clk) begin
		if (reset) begin
			ext_flag   <= 1'b0;
			break_flag <= 1'b0;
		end else if (state == ST_IDLE) begin
			ext_flag   <= rx_valid && rx_byte == PREFIX_EXT;
			break_flag <= rx_valid && rx_byte == PREFIX_BREAK;
		end else if (code_take) begin
			ext_flag   <= 1'b0;
			break_flag <= 1'b0;
		end else if (rx_valid && next_state == ST_BREAK_SEEN) begin
			break_flag <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= code_take;
		end
	end

	always_ff @(posedge clk) begin
		if (code_take) begin
			cmd_code   <= rx_byte;
			cmd_action <= break_flag ? ACT_RELEASE : ACT_PRESS;
			cmd_ext    <= ext_flag;
		end
	end

	// Every command comes from a received byte.
	a_cmd_after_rx: assert property (
		@(posedge clk) disable iff (reset)
		cmd_valid |-> $past(rx_valid)
	);

endmodule

/* ps2_receiver.sv */
`timescale 1ns/1ps

module ps2_receiver (
	input  logic                clk,
	input  logic                reset,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	output kbd_pkg::scan_code_t rx_byte,
	output logic                rx_valid
);
	import kbd_pkg::*;

	// Start, data, parity and stop bits.
	localparam int FRAME_W = SCAN_W + 3;

	logic               clk_meta;
	logic               clk_sync;
	logic               clk_last;
	logic               data_meta;
	logic               data_sync;
	logic               clk_fall;
	logic [FRAME_W-1:0] shift_reg;
	logic [3:0]         bit_cnt;
	logic               frame_done;
	logic               start_ok;
	logic               parity_ok;
	logic               stop_ok;

	// Both lines idle high.
	always_ff @(posedge clk) begin
		if (reset) begin
			clk_meta  <= 1'b1;
			clk_sync  <= 1'b1;
			clk_last  <= 1'b1;
			data_meta <= 1'b1;
			data_sync <= 1'b1;
		end else begin
			clk_meta  <= ps2_clk;
			clk_sync  <= clk_meta;
			clk_last  <= clk_sync;
			data_meta <= ps2_data;
			data_sync <= data_meta;
		end
	end

	assign clk_fall = clk_last & ~clk_sync;

	// LSB first, so shift in from the top.
	always_ff @(posedge clk) begin
		if (clk_fall) begin
			shift_reg <= {data_sync, shift_reg[FRAME_W-1:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt    <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'(FRAME_W - 1)) begin
					bit_cnt    <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// Frame checks on the completed shift register.
	assign start_ok  = ~shift_reg[0];
	assign parity_ok = ^shift_reg[FRAME_W-2:1];
	assign stop_ok   = shift_reg[FRAME_W-1];

	// Bad frames are dropped without a strobe.
	assign rx_valid = frame_done & start_ok & parity_ok & stop_ok;
	assign rx_byte  = shift_reg[SCAN_W:1];

	// A frame takes many clocks, so strobes never touch.
	a_rx_valid_single: assert property (
		@(posedge clk) disable iff (reset)
		rx_valid |=> !rx_valid
	);

endmodule

/* tb_keyboard_parser.sv */
`timescale 1ns/1ps

module tb_keyboard_parser;

	localparam int NUM_KEYS   = 128;
	localparam int NUM_FRAMES = 400;
	localparam int SEED       = 80871;
	localparam int HALF_BIT   = 6;
	// Frames, 11 bits, 12 clocks per bit, 100 ns per clock, doubled.
	localparam int WATCHDOG_NS = NUM_FRAMES * 11 * 12 * 100 * 2;

	logic                clk;
	logic                reset;
	logic                ps2_clk;
	logic                ps2_data;
	logic [NUM_KEYS-1:0] key_data;
	logic [NUM_KEYS-1:0] ext_key_data;
	int                  error_count;
	int                  check_count;
	int                  frames_sent;
	logic [7:0]          code;

	keyboard_parser #(
		.NUM_KEYS (NUM_KEYS)
	) u_dut (
		.clk          (clk),
		.reset        (reset),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.key_data     (key_data),
		.ext_key_data (ext_key_data)
	);

	kbd_checker #(
		.NUM_KEYS (NUM_KEYS)
	) u_checker (
		.clk          (clk),
		.reset        (reset),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.key_data     (key_data),
		.ext_key_data (ext_key_data),
		.error_count  (error_count),
		.check_count  (check_count)
	);

	always #50 clk = ~clk;

	// One frame, entered and left on a falling clk edge.
	task automatic drive_frame(input logic [7:0] data, input logic bad_parity,
		input logic bad_stop);
		logic [10:0] bits;
		bits = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[0];
			bits     = bits >> 1;
			repeat (HALF_BIT) @(negedge clk);
			ps2_clk = 1'b0;
			repeat (HALF_BIT) @(negedge clk);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		repeat (20) @(negedge clk);
		frames_sent++;
	endtask

	// Sometimes a broken frame slips in ahead of the byte.
	task automatic send_byte(input logic [7:0] data);
		int kind;
		kind = int'($urandom_range(0, 11));
		if (kind == 0) begin
			drive_frame(8'($urandom), 1'b1, 1'b0);
		end else if (kind == 1) begin
			drive_frame(8'($urandom), 1'b0, 1'b1);
		end
		drive_frame(data, 1'b0, 1'b0);
	endtask

	// 0 make, 1 break, 2 extended make, 3 extended break.
	task automatic emit_key_event(input int kind, input logic [7:0] key);
		if (kind >= 2) begin
			send_byte(8'hE0);
		end
		if (kind == 1 || kind == 3) begin
			send_byte(8'hF0);
		end
		send_byte(key);
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		ps2_clk     = 1'b1;
		ps2_data    = 1'b1;
		frames_sent = 0;
		code        = '0;
		void'($urandom(SEED));
		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (20) @(negedge clk);

		// Directed sequences first.
		drive_frame(8'h1C, 1'b0, 1'b0);
		drive_frame(8'hF0, 1'b0, 1'b0);
		drive_frame(8'h1C, 1'b0, 1'b0);
		drive_frame(8'hE0, 1'b0, 1'b0);
		drive_frame(8'h75, 1'b0, 1'b0);
		drive_frame(8'hE0, 1'b0, 1'b0);
		drive_frame(8'hF0, 1'b0, 1'b0);
		drive_frame(8'h75, 1'b0, 1'b0);
		drive_frame(8'hF0, 1'b0, 1'b0);
		drive_frame(8'hE0, 1'b0, 1'b0);
		drive_frame(8'hF0, 1'b0, 1'b0);
		drive_frame(8'hF0, 1'b0, 1'b0);
		drive_frame(8'hE0, 1'b0, 1'b0);
		drive_frame(8'h12, 1'b1, 1'b0);
		drive_frame(8'h6B, 1'b0, 1'b0);
		drive_frame(8'h33, 1'b0, 1'b1);
		drive_frame(8'h2A, 1'b0, 1'b0);

		while (frames_sent < NUM_FRAMES) begin
			if ($urandom_range(0, 1) == 1) begin
				code = 8'($urandom_range(0, 255));
			end else begin
				code = 8'($urandom_range(0, 15));
			end
			emit_key_event(int'($urandom_range(0, 3)), code);
		end
		repeat (40) @(negedge clk);

		$display("Closing: %0d frames, %0d bitmap checks, %0d errors",
			frames_sent, check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			if (check_count == 0) begin
				$display("No bitmap comparison was made during the run.");
			end
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule
